/* source/reg_core_defines.svh */
`ifndef REG_CORE_DEFINES_SVH
`define REG_CORE_DEFINES_SVH

// data path width
`define WORD_W 32

// 32 architectural registers
`define REG_ADDR_W 5

// one bit per outstanding branch level
`define CONTEXT_W 4

// x1 holds the return address
`define LR_ADDR 1

`endif

/* source/reg_core_pkg.sv */
`include "reg_core_defines.svh"

package reg_core_pkg;

    typedef logic [`WORD_W-1:0] word_t;

    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    // branch context mask, a set bit ties a write to that branch level
    typedef logic [`CONTEXT_W-1:0] context_t;

    // op_li ignores rs2 and takes the immediate as operand b
    typedef enum logic [2:0] {
        op_add,
        op_sub,
        op_and,
        op_or,
        op_xor,
        op_shl,
        op_li
    } alu_op_e;

endpackage

/* source/reg_file.sv */
`include "reg_core_defines.svh"

module reg_file (
    input  logic                  clk,
    input  logic                  rst_n,
    input  reg_core_pkg::reg_addr_t ra1,
    input  reg_core_pkg::reg_addr_t ra2,
    output reg_core_pkg::word_t   rd1,
    output reg_core_pkg::word_t   rd2,
    input  logic                  we,
    input  reg_core_pkg::reg_addr_t wa,
    input  reg_core_pkg::word_t   wd
);

    import reg_core_pkg::*;

    localparam int NUM_REGS = 1 << `REG_ADDR_W;

    // x0 has no storage
    word_t regs [1:NUM_REGS-1];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (wa != '0)) begin
            regs[wa] <= wd;
        end
    end

    // combinational reads, x0 reads zero
    always_comb begin
        if (ra1 == '0) begin
            rd1 = '0;
        end else begin
            rd1 = regs[ra1];
        end
    end

    always_comb begin
        if (ra2 == '0) begin
            rd2 = '0;
        end else begin
            rd2 = regs[ra2];
        end
    end

endmodule

/* source/reg_scoreboard.sv */
`include "reg_core_defines.svh"

module reg_scoreboard (
    input  logic                    clk,
    input  logic                    rst_n,

    // issue side
    input  logic                    issue_valid,
    input  reg_core_pkg::alu_op_e   issue_op,
    input  reg_core_pkg::reg_addr_t issue_rs1,
    input  reg_core_pkg::reg_addr_t issue_rs2,
    input  reg_core_pkg::reg_addr_t issue_rd,
    input  reg_core_pkg::word_t     issue_imm,
    input  reg_core_pkg::context_t  issue_context,
    output logic                    issue_stall,

    // branch flush
    input  logic                    branch_hazard,
    input  reg_core_pkg::context_t  hazard_context,

    // writeback from the execute pipe
    input  logic                    wb_valid,
    input  reg_core_pkg::reg_addr_t wb_rd,
    input  reg_core_pkg::word_t     wb_data,

    // register file read ports
    output reg_core_pkg::reg_addr_t ra1,
    output reg_core_pkg::reg_addr_t ra2,
    input  reg_core_pkg::word_t     rd1,
    input  reg_core_pkg::word_t     rd2,

    // execute pipe inputs
    output logic                    ex_valid,
    output reg_core_pkg::alu_op_e   ex_op,
    output reg_core_pkg::word_t     ex_a,
    output reg_core_pkg::word_t     ex_b,
    output reg_core_pkg::reg_addr_t ex_rd,
    output reg_core_pkg::context_t  ex_context,

    output logic                    lr_dirty
);

    import reg_core_pkg::*;

    localparam int NUM_REGS = 1 << `REG_ADDR_W;

    // one pending bit and issue context per register, bit 0 stays clear
    logic [NUM_REGS-1:0] pending;
    context_t            pend_context [NUM_REGS];

    logic  wb_hit_rs1;
    logic  wb_hit_rs2;
    logic  wb_hit_rd;
    logic  rs1_busy;
    logic  rs2_busy;
    logic  rd_busy;
    logic  issue_fire;
    word_t opnd_a;
    word_t opnd_b;

    // writeback in this cycle resolves the hazard on that register
    assign wb_hit_rs1 = wb_valid && (wb_rd == issue_rs1);
    assign wb_hit_rs2 = wb_valid && (wb_rd == issue_rs2);
    assign wb_hit_rd  = wb_valid && (wb_rd == issue_rd);

    assign rs1_busy = pending[issue_rs1] && !wb_hit_rs1;
    assign rs2_busy = pending[issue_rs2] && !wb_hit_rs2;
    assign rd_busy  = pending[issue_rd] && !wb_hit_rd;

    // nothing issues under a flush
    assign issue_stall = branch_hazard || rs1_busy || rs2_busy || rd_busy;
    assign issue_fire  = issue_valid && !issue_stall;

    assign ra1 = issue_rs1;
    assign ra2 = issue_rs2;

    // bypass from writeback, x0 never bypassed
    always_comb begin
        if (wb_hit_rs1 && (issue_rs1 != '0)) begin
            opnd_a = wb_data;
        end else begin
            opnd_a = rd1;
        end
    end

    always_comb begin
        if (issue_op == op_li) begin
            opnd_b = issue_imm;
        end else if (wb_hit_rs2 && (issue_rs2 != '0)) begin
            opnd_b = wb_data;
        end else begin
            opnd_b = rd2;
        end
    end

    assign ex_valid   = issue_fire;
    assign ex_op      = issue_op;
    assign ex_a       = opnd_a;
    assign ex_b       = opnd_b;
    assign ex_rd      = issue_rd;
    assign ex_context = issue_context;

    // set on issue beats clear by writeback or flush
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pending <= '0;
            for (int i = 0; i < NUM_REGS; i++) begin
                pend_context[i] <= '0;
            end
        end else begin
            for (int i = 1; i < NUM_REGS; i++) begin
                if (issue_fire && (issue_rd == reg_addr_t'(i))) begin
                    pending[i]      <= 1'b1;
                    pend_context[i] <= issue_context;
                end else if (wb_valid && (wb_rd == reg_addr_t'(i))) begin
                    pending[i]      <= 1'b0;
                    pend_context[i] <= '0;
                end else if (branch_hazard && |(pend_context[i] & hazard_context)) begin
                    // squashed by the branch
                    pending[i]      <= 1'b0;
                    pend_context[i] <= '0;
                end
            end
        end
    end

    assign lr_dirty = pending[`LR_ADDR];

endmodule

/* source/exec_pipe.sv */
`include "reg_core_defines.svh"

module exec_pipe (
    input  logic                    clk,
    input  logic                    rst_n,

    input  logic                    ex_valid,
    input  reg_core_pkg::alu_op_e   ex_op,
    input  reg_core_pkg::word_t     ex_a,
    input  reg_core_pkg::word_t     ex_b,
    input  reg_core_pkg::reg_addr_t ex_rd,
    input  reg_core_pkg::context_t  ex_context,

    input  logic                    branch_hazard,
    input  reg_core_pkg::context_t  hazard_context,

    output logic                    wb_valid,
    output reg_core_pkg::reg_addr_t wb_rd,
    output reg_core_pkg::word_t     wb_data
);

    import reg_core_pkg::*;

    localparam int SHAMT_W = $clog2(`WORD_W);

    // stage 1 holds the issued op and its operands
    logic      s1_valid;
    alu_op_e   s1_op;
    word_t     s1_a;
    word_t     s1_b;
    reg_addr_t s1_rd;
    context_t  s1_context;

    logic  s1_squash;
    word_t alu_result;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= ex_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_op      <= ex_op;
        s1_a       <= ex_a;
        s1_b       <= ex_b;
        s1_rd      <= ex_rd;
        s1_context <= ex_context;
    end

    always_comb begin
        case (s1_op)
            op_add:  alu_result = s1_a + s1_b;
            op_sub:  alu_result = s1_a - s1_b;
            op_and:  alu_result = s1_a & s1_b;
            op_or:   alu_result = s1_a | s1_b;
            op_xor:  alu_result = s1_a ^ s1_b;
            op_shl:  alu_result = s1_a << s1_b[SHAMT_W-1:0];
            op_li:   alu_result = s1_b;
            default: alu_result = '0;
        endcase
    end

    // overlapping branch context kills the op before writeback
    assign s1_squash = branch_hazard && |(s1_context & hazard_context);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= s1_valid && !s1_squash;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd   <= s1_rd;
        wb_data <= alu_result;
    end

endmodule

/* source/reg_core_top.sv */
module reg_core_top (
    input  logic                    clk,
    input  logic                    rst_n,

    input  logic                    issue_valid,
    input  reg_core_pkg::alu_op_e   issue_op,
    input  reg_core_pkg::reg_addr_t issue_rs1,
    input  reg_core_pkg::reg_addr_t issue_rs2,
    input  reg_core_pkg::reg_addr_t issue_rd,
    input  reg_core_pkg::word_t     issue_imm,
    input  reg_core_pkg::context_t  issue_context,
    output logic                    issue_stall,

    input  logic                    branch_hazard,
    input  reg_core_pkg::context_t  hazard_context,

    output logic                    wb_valid,
    output reg_core_pkg::reg_addr_t wb_rd,
    output reg_core_pkg::word_t     wb_data,
    output logic                    lr_dirty
);

    import reg_core_pkg::*;

    // register file reads
    reg_addr_t ra1;
    reg_addr_t ra2;
    word_t     rd1;
    word_t     rd2;

    // scoreboard to execute pipe
    logic      ex_valid;
    alu_op_e   ex_op;
    word_t     ex_a;
    word_t     ex_b;
    reg_addr_t ex_rd;
    context_t  ex_context;

    reg_scoreboard u_scoreboard (
        .clk            (clk),
        .rst_n          (rst_n),
        .issue_valid    (issue_valid),
        .issue_op       (issue_op),
        .issue_rs1      (issue_rs1),
        .issue_rs2      (issue_rs2),
        .issue_rd       (issue_rd),
        .issue_imm      (issue_imm),
        .issue_context  (issue_context),
        .issue_stall    (issue_stall),
        .branch_hazard  (branch_hazard),
        .hazard_context (hazard_context),
        .wb_valid       (wb_valid),
        .wb_rd          (wb_rd),
        .wb_data        (wb_data),
        .ra1            (ra1),
        .ra2            (ra2),
        .rd1            (rd1),
        .rd2            (rd2),
        .ex_valid       (ex_valid),
        .ex_op          (ex_op),
        .ex_a           (ex_a),
        .ex_b           (ex_b),
        .ex_rd          (ex_rd),
        .ex_context     (ex_context),
        .lr_dirty       (lr_dirty)
    );

    reg_file u_reg_file (
        .clk   (clk),
        .rst_n (rst_n),
        .ra1   (ra1),
        .ra2   (ra2),
        .rd1   (rd1),
        .rd2   (rd2),
        .we    (wb_valid),
        .wa    (wb_rd),
        .wd    (wb_data)
    );

    exec_pipe u_exec_pipe (
        .clk            (clk),
        .rst_n          (rst_n),
        .ex_valid       (ex_valid),
        .ex_op          (ex_op),
        .ex_a           (ex_a),
        .ex_b           (ex_b),
        .ex_rd          (ex_rd),
        .ex_context     (ex_context),
        .branch_hazard  (branch_hazard),
        .hazard_context (hazard_context),
        .wb_valid       (wb_valid),
        .wb_rd          (wb_rd),
        .wb_data        (wb_data)
    );

endmodule

/* sim/clk_gen.sv */
module clk_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // low across the first two rising edges, released on a falling edge
    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

/* sim/reg_core_assertions.sv */
`include "reg_core_defines.svh"

module reg_core_assertions (
    input logic                          clk,
    input logic                          rst_n,
    input logic                          branch_hazard,
    input logic                          s1_valid,
    input logic                          wb_valid,
    input reg_core_pkg::reg_addr_t       wb_rd,
    input logic [(1<<`REG_ADDR_W)-1:0]   pending
);

    // nothing enters the execute pipe at a flush edge
    a_no_issue_under_flush: assert property (
        @(posedge clk) disable iff (!rst_n)
        branch_hazard |=> !s1_valid
    ) else $error("instruction accepted during a branch flush");

    // result must belong to a register that still waits for it
    a_wb_hits_pending: assert property (
        @(posedge clk) disable iff (!rst_n)
        (wb_valid && (wb_rd != '0)) |-> pending[wb_rd]
    ) else $error("writeback to a register that is not pending");

    a_wb_valid_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        !$isunknown(wb_valid)
    ) else $error("wb_valid is unknown after reset");

endmodule

/* sim/tb_reg_core.sv */
`include "reg_core_defines.svh"

module tb_reg_core;

    import reg_core_pkg::*;

    localparam int          NUM_REGS    = 1 << `REG_ADDR_W;
    localparam int          NUM_RANDOM  = 300;
    localparam int          STALL_LIMIT = 20;
    localparam int          DRAIN_LIMIT = 20;
    localparam int          RESET_LIMIT = 10;
    localparam logic [31:0] SEED        = 32'h8cff0cc4;

    typedef struct packed {
        reg_addr_t   rd;
        word_t       data;
        logic [31:0] accept_edge;
    } wb_entry_t;

    logic      clk;
    logic      rst_n;
    logic      issue_valid;
    alu_op_e   issue_op;
    reg_addr_t issue_rs1;
    reg_addr_t issue_rs2;
    reg_addr_t issue_rd;
    word_t     issue_imm;
    context_t  issue_context;
    logic      issue_stall;
    logic      branch_hazard;
    context_t  hazard_context;
    logic      wb_valid;
    reg_addr_t wb_rd;
    word_t     wb_data;
    logic      lr_dirty;

    // speculative register values updated at acceptance
    word_t             model_regs [NUM_REGS];
    logic [NUM_REGS-1:0] model_pending;
    wb_entry_t         exp_q [$];
    int unsigned       cycle_count = 0;

    clk_gen u_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    reg_core_top dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .issue_valid    (issue_valid),
        .issue_op       (issue_op),
        .issue_rs1      (issue_rs1),
        .issue_rs2      (issue_rs2),
        .issue_rd       (issue_rd),
        .issue_imm      (issue_imm),
        .issue_context  (issue_context),
        .issue_stall    (issue_stall),
        .branch_hazard  (branch_hazard),
        .hazard_context (hazard_context),
        .wb_valid       (wb_valid),
        .wb_rd          (wb_rd),
        .wb_data        (wb_data),
        .lr_dirty       (lr_dirty)
    );

    bind reg_core_top reg_core_assertions u_assertions (
        .clk           (clk),
        .rst_n         (rst_n),
        .branch_hazard (branch_hazard),
        .s1_valid      (u_exec_pipe.s1_valid),
        .wb_valid      (wb_valid),
        .wb_rd         (wb_rd),
        .pending       (u_scoreboard.pending)
    );

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERROR time=%0t signal=%s actual=0x%08h expected=0x%08h",
                     $time, name, actual, expected);
            $display("Result: FAILED");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Result: FAILED");
        $fatal(1, "stopped on a failed wait");
    endtask

    function automatic word_t alu_ref(input alu_op_e op, input word_t a, input word_t b);
        case (op)
            op_add:  return a + b;
            op_sub:  return a - b;
            op_and:  return a & b;
            op_or:   return a | b;
            op_xor:  return a ^ b;
            op_shl:  return a << b[4:0];
            op_li:   return b;
            default: return '0;
        endcase
    endfunction

    // a writeback seen this cycle has already cleared its model bit
    function automatic logic expected_stall(input reg_addr_t rs1, input reg_addr_t rs2,
                                            input reg_addr_t rd);
        return branch_hazard || model_pending[rs1] || model_pending[rs2] || model_pending[rd];
    endfunction

    task automatic wait_for_reset();
        int waited;
        waited = 0;
        while (!rst_n) begin
            waited++;
            if (waited > RESET_LIMIT) report_failure("reset was never released");
            @(negedge clk);
            #1;
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge clk);
            issue_valid = 1'b0;
        end
    endtask

    // squash marks an op that a flush is expected to kill
    task automatic issue_instr(input alu_op_e op, input reg_addr_t rs1, input reg_addr_t rs2,
                               input reg_addr_t rd, input word_t imm, input context_t ctx,
                               input bit squash, output int stalls);
        wb_entry_t entry;
        word_t     b;
        stalls = 0;
        @(negedge clk);
        issue_valid   = 1'b1;
        issue_op      = op;
        issue_rs1     = rs1;
        issue_rs2     = rs2;
        issue_rd      = rd;
        issue_imm     = imm;
        issue_context = ctx;
        #1;
        check_value("issue_stall", 32'(issue_stall), 32'(expected_stall(rs1, rs2, rd)));
        while (issue_stall) begin
            stalls++;
            if (stalls > STALL_LIMIT) report_failure("issue stalled past the timeout");
            @(negedge clk);
            #1;
            check_value("issue_stall", 32'(issue_stall), 32'(expected_stall(rs1, rs2, rd)));
        end
        if (!squash) begin
            b = (op == op_li) ? imm : model_regs[rs2];
            entry.rd          = rd;
            entry.data        = alu_ref(op, model_regs[rs1], b);
            entry.accept_edge = cycle_count + 1;
            exp_q.push_back(entry);
            model_regs[rd] = entry.data;
        end
        @(posedge clk);
        if (!squash) begin
            model_pending[rd] = 1'b1;
        end
    endtask

    task automatic drain_pipe();
        int waited;
        waited = 0;
        @(negedge clk);
        issue_valid = 1'b0;
        #2;
        while (exp_q.size() != 0) begin
            waited++;
            if (waited > DRAIN_LIMIT) report_failure("writebacks did not drain");
            @(negedge clk);
            #2;
        end
    endtask

    // registered outputs are settled by the falling edge
    initial begin : compare_writebacks
        wb_entry_t head;
        forever begin
            @(negedge clk);
            if (rst_n && wb_valid) begin
                if (exp_q.size() == 0) report_failure("writeback with no instruction in flight");
                head = exp_q.pop_front();
                check_value("wb_rd", 32'(wb_rd), 32'(head.rd));
                check_value("wb_data", wb_data, head.data);
                check_value("wb_latency", cycle_count, head.accept_edge + 32'd1);
                model_pending[head.rd] = 1'b0;
            end
        end
    end

    initial begin : stimulus
        int        stalls;
        alu_op_e   op;
        reg_addr_t rs2;
        issue_valid    = 1'b0;
        issue_op       = op_add;
        issue_rs1      = '0;
        issue_rs2      = '0;
        issue_rd       = '0;
        issue_imm      = '0;
        issue_context  = '0;
        branch_hazard  = 1'b0;
        hazard_context = '0;
        model_pending  = '0;
        for (int i = 0; i < NUM_REGS; i++) begin
            model_regs[i] = '0;
        end
        void'($urandom(SEED));
        wait_for_reset();
        check_value("wb_valid", 32'(wb_valid), 32'd0);
        check_value("lr_dirty", 32'(lr_dirty), 32'd0);

        // read reset contents and load a few registers
        issue_instr(op_add, 5'd8, 5'd9, 5'd7, '0, '0, 1'b0, stalls);
        for (int r = 2; r < 6; r++) begin
            issue_instr(op_li, '0, '0, reg_addr_t'(r), $urandom(), '0, 1'b0, stalls);
        end
        issue_instr(op_add, '0, '0, 5'd6, '0, '0, 1'b0, stalls);
        drain_pipe();

        // dependent op waits one cycle and takes the bypass
        issue_instr(op_li, '0, '0, 5'd10, $urandom(), '0, 1'b0, stalls);
        issue_instr(op_add, 5'd10, 5'd10, 5'd11, '0, '0, 1'b0, stalls);
        check_value("dependent_stall_cycles", stalls, 32'd1);
        drain_pipe();

        // link register flag follows x1 pending
        issue_instr(op_li, '0, '0, reg_addr_t'(`LR_ADDR), $urandom(), '0, 1'b0, stalls);
        idle_cycles(1);
        #1;
        check_value("lr_dirty", 32'(lr_dirty), 32'd1);
        idle_cycles(1);
        #1;
        check_value("lr_dirty", 32'(lr_dirty), 32'd1);
        idle_cycles(1);
        #1;
        check_value("lr_dirty", 32'(lr_dirty), 32'd0);

        // flush the stage-1 op so x12 keeps its older value
        issue_instr(op_li, '0, '0, 5'd12, $urandom(), '0, 1'b0, stalls);
        drain_pipe();
        issue_instr(op_li, '0, '0, 5'd12, $urandom(), 4'b0010, 1'b1, stalls);
        @(negedge clk);
        issue_valid    = 1'b0;
        branch_hazard  = 1'b1;
        hazard_context = 4'b0011;
        #1;
        check_value("issue_stall", 32'(issue_stall), 32'd1);
        @(negedge clk);
        branch_hazard  = 1'b0;
        hazard_context = '0;
        idle_cycles(2);
        issue_instr(op_or, 5'd12, '0, 5'd13, '0, '0, 1'b0, stalls);
        check_value("flushed_reg_stall_cycles", stalls, 32'd0);
        drain_pipe();

        // random stream over all opcodes with random gaps
        for (int n = 0; n < NUM_RANDOM; n++) begin
            op  = alu_op_e'($urandom_range(6, 0));
            rs2 = (op == op_li) ? reg_addr_t'(0) : reg_addr_t'($urandom_range(31, 0));
            issue_instr(op, reg_addr_t'($urandom_range(31, 0)), rs2,
                        reg_addr_t'($urandom_range(31, 1)), $urandom(),
                        context_t'($urandom_range(15, 0)), 1'b0, stalls);
            idle_cycles(int'($urandom_range(2, 0)));
        end
        drain_pipe();

        $display("Result: PASSED");
        $finish;
    end

endmodule

/* src.f */
+incdir+source
source/reg_core_pkg.sv
source/reg_file.sv
source/reg_scoreboard.sv
source/exec_pipe.sv
source/reg_core_top.sv
sim/clk_gen.sv
sim/reg_core_assertions.sv
sim/tb_reg_core.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f src.f --top-module tb_reg_core -o Vtb_reg_core

# the log decides the outcome
./obj_dir/Vtb_reg_core > sim.log 2>&1 || true
cat sim.log

if grep -q "Result: PASSED" sim.log; then
    echo "simulation run succeeded"
    exit 0
else
    echo "simulation run failed"
    exit 1
fi
